// ==== cgra_conf_top.f ====
+incdir+rtl
rtl/cgra_conf_pkg.sv
rtl/cgra_conf_regs.sv
rtl/cgra_conf_line_fetch.sv
rtl/cgra_pe_conf_control.sv
rtl/cgra_pe_conf_bank.sv
rtl/cgra_conf_top.sv
verification/tb_conf_mem_model.sv
verification/tb_cgra_conf.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f cgra_conf_top.f --top-module tb_cgra_conf \
  -Mdir "$build_dir" -o tb_cgra_conf
if [ $? -ne 0 ]; then
  echo "Verilator build failed."
  exit 1
fi

"./$build_dir/tb_cgra_conf" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status."
  exit 1
fi

if grep -q ">>> FAIL" "$log_file"; then
  exit 1
fi
exit 0

// ==== verification/tb_cgra_conf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module tb_cgra_conf;

  import cgra_conf_pkg::*;

  localparam int IMAGE_LINES = 64;
  localparam int POLL_LIMIT = 5000;
  localparam logic [1:0] ADDR_COUNT  = 2'd0;
  localparam logic [1:0] ADDR_BASE   = 2'd1;
  localparam logic [1:0] ADDR_CTRL   = 2'd2;
  localparam logic [1:0] ADDR_STATUS = 2'd3;

  typedef logic [`CGRA_NUM_PE-1:0][`CGRA_PE_CONF_WIDTH-1:0] bank_t;
  typedef logic [`CGRA_CL_WIDTH-1:0] line_t;

  logic clk;
  logic rst;
  csr_req_t csr;
  logic [`CGRA_WORD_WIDTH-1:0] csr_rdata;
  logic mem_ready;
  logic mem_rd_en;
  logic [`CGRA_ADDR_WIDTH-1:0] mem_rd_addr;
  line_t mem_rd_data;
  logic mem_rd_valid;
  bank_t pe_conf;
  logic [6:0] gap_pct;
  logic [31:0] read_count;
  bank_t exp_bank;
  int errors;
  int tests_run;
  int tests_failed;

  cgra_conf_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .csr          (csr),
    .csr_rdata    (csr_rdata),
    .mem_ready    (mem_ready),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_addr  (mem_rd_addr),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .pe_conf      (pe_conf)
  );

  tb_conf_mem_model #(.IMAGE_LINES(IMAGE_LINES)) mem_i (
    .clk          (clk),
    .rst          (rst),
    .gap_pct      (gap_pct),
    .mem_rd_en    (mem_rd_en),
    .mem_rd_addr  (mem_rd_addr),
    .mem_ready    (mem_ready),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_valid (mem_rd_valid),
    .read_count   (read_count)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Word i of a run is slot i mod 16 of line base + i / 16, applied in order.
  function automatic bank_t expected_bank(input bank_t prev, input line_t img [IMAGE_LINES],
                                          input int unsigned base, input int unsigned count);
    bank_t bank;
    conf_word_t w;
    int unsigned line;
    int unsigned slot;
    bank = prev;
    for (int unsigned i = 0; i < count; i++) begin
      line = (base + i / `CGRA_WORDS_PER_CL) % IMAGE_LINES;
      slot = i % `CGRA_WORDS_PER_CL;
      w = img[line][slot*`CGRA_WORD_WIDTH +: `CGRA_WORD_WIDTH];
      if (w.pe_id < `CGRA_NUM_PE) begin
        bank[w.pe_id] = w.pe_conf;
      end
    end
    return bank;
  endfunction

  task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #1;
    csr = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
    @(posedge clk);
    #1;
    csr = '0;
  endtask

  task automatic csr_read(input logic [1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #1;
    csr = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
    #3;
    data = csr_rdata;
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_bank();
    for (int n = 0; n < `CGRA_NUM_PE; n++) begin
      assert (pe_conf[n] === exp_bank[n]) else begin
        $display("mismatch pe_conf[%0d] expected %h actual %h", n, exp_bank[n], pe_conf[n]);
        errors++;
      end
    end
  endtask

  task automatic wait_done(input int unsigned base);
    logic [31:0] st;
    int polls;
    st = '0;
    polls = 0;
    while ((st[0] !== 1'b1) && (polls < POLL_LIMIT)) begin
      csr_read(ADDR_STATUS, st);
      polls++;
    end
    if (st[0] !== 1'b1) begin
      $display("timeout: the load from base line %0d never reported done", base);
      errors++;
    end
  endtask

  // The status read right after the control write shows whether done cleared.
  task automatic run_load(input int unsigned base, input int unsigned count,
                          output logic [31:0] first_status);
    csr_write(ADDR_COUNT, count);
    csr_write(ADDR_BASE, base);
    csr_write(ADDR_CTRL, 32'h1);
    csr_read(ADDR_STATUS, first_status);
    wait_done(base);
    exp_bank = expected_bank(exp_bank, mem_i.image, base, count);
  endtask

  task automatic end_test(input int num, input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %0d (%s): ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d (%s): %0d errors", num, name, errors - err_mark);
    end
  endtask

  initial begin
    int err_mark;
    logic [31:0] status;
    logic [31:0] reads_before;
    void'($urandom(32'h18bb21f3));
    rst = 1'b1;
    csr = '0;
    gap_pct = 7'd20;
    exp_bank = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    err_mark = errors;
    mem_i.fill_lines(0, 3, 1'b0);
    compare_bank();
    run_load(0, 48, status);
    compare_bank();
    end_test(1, "three full lines", err_mark);

    err_mark = errors;
    reads_before = read_count;
    mem_i.fill_lines(4, 2, 1'b0);
    run_load(4, 20, status);
    compare_bank();
    check_value("read_count", read_count - reads_before, 32'd2);
    end_test(2, "partial second line", err_mark);

    err_mark = errors;
    reads_before = read_count;
    run_load(8, 0, status);
    compare_bank();
    check_value("read_count", read_count - reads_before, 32'd0);
    end_test(3, "zero count", err_mark);

    err_mark = errors;
    mem_i.fill_lines(10, 3, 1'b1);
    run_load(10, 48, status);
    compare_bank();
    end_test(4, "ids outside the bank", err_mark);

    err_mark = errors;
    mem_i.fill_lines(16, 5, 1'b0);
    run_load(16, 48, status);
    check_value("status", status & 32'h3, 32'h2);
    compare_bank();
    run_load(19, 32, status);
    check_value("status", status & 32'h3, 32'h2);
    compare_bank();
    end_test(5, "restart from done", err_mark);

    err_mark = errors;
    @(posedge clk);
    #1;
    gap_pct = 7'd70;
    mem_i.fill_lines(24, 10, 1'b0);
    run_load(24, 160, status);
    compare_bank();
    gap_pct = 7'd20;
    end_test(6, "long run with ready gaps", err_mark);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tb_conf_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module tb_conf_mem_model #(
  parameter int IMAGE_LINES = 64
) (
  input  wire                            clk,
  input  wire                            rst,
  input  wire [6:0]                      gap_pct,
  input  wire                            mem_rd_en,
  input  wire [`CGRA_ADDR_WIDTH-1:0]     mem_rd_addr,
  output logic                           mem_ready,
  output logic [`CGRA_CL_WIDTH-1:0]      mem_rd_data,
  output logic                           mem_rd_valid,
  output logic [31:0]                    read_count
);

  import cgra_conf_pkg::*;

  logic [`CGRA_CL_WIDTH-1:0] image [IMAGE_LINES];
  logic pending;
  int unsigned delay;
  logic [`CGRA_ADDR_WIDTH-1:0] pend_addr;

  // Random words. Without wide_ids every id stays inside the bank.
  task automatic fill_lines(input int unsigned first, input int unsigned num,
                            input bit wide_ids);
    conf_word_t w;
    int unsigned idx;
    for (int unsigned l = 0; l < num; l++) begin
      idx = (first + l) % IMAGE_LINES;
      for (int unsigned k = 0; k < `CGRA_WORDS_PER_CL; k++) begin
        w = $urandom;
        if (!wide_ids) begin
          w.pe_id[`CGRA_PE_ID_WIDTH-1] = 1'b0;
        end
        image[idx][k*`CGRA_WORD_WIDTH +: `CGRA_WORD_WIDTH] = w;
      end
    end
  endtask

  // All sampling and driving happens 1 ns after the rising edge.
  initial begin
    for (int i = 0; i < IMAGE_LINES; i++) begin
      image[i] = '0;
    end
    mem_ready    = 1'b0;
    mem_rd_data  = '0;
    mem_rd_valid = 1'b0;
    read_count   = '0;
    pending      = 1'b0;
    delay        = 0;
    pend_addr    = '0;
    forever begin
      @(posedge clk);
      #1;
      mem_rd_valid = 1'b0;
      if (rst) begin
        pending   = 1'b0;
        mem_ready = 1'b0;
      end else begin
        if (pending) begin
          delay = delay - 1;
          if (delay == 0) begin
            mem_rd_valid = 1'b1;
            mem_rd_data  = image[pend_addr % IMAGE_LINES];
            pending      = 1'b0;
          end
        end
        if (mem_rd_en) begin
          pending    = 1'b1;
          pend_addr  = mem_rd_addr;
          delay      = $urandom_range(8, 1);
          read_count = read_count + 1;
        end
        mem_ready = ($urandom_range(99, 0) >= gap_pct);
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cgra_conf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module cgra_conf_top (
  input  wire                              clk,
  input  wire                              rst,
  input  wire cgra_conf_pkg::csr_req_t     csr,
  output logic [`CGRA_WORD_WIDTH-1:0]      csr_rdata,
  input  wire                              mem_ready,
  output logic                             mem_rd_en,
  output logic [`CGRA_ADDR_WIDTH-1:0]      mem_rd_addr,
  input  wire [`CGRA_CL_WIDTH-1:0]         mem_rd_data,
  input  wire                              mem_rd_valid,
  output logic [`CGRA_NUM_PE-1:0][`CGRA_PE_CONF_WIDTH-1:0] pe_conf
);

  import cgra_conf_pkg::*;

  logic start;
  logic done;
  logic [`CGRA_WORD_WIDTH-1:0] qtd_conf;
  logic [`CGRA_ADDR_WIDTH-1:0] base_addr;
  logic req_rd_data;
  logic available_read;
  logic [`CGRA_CL_WIDTH-1:0] rd_data;
  logic rd_data_valid;
  conf_bus_t conf_bus;

  cgra_conf_regs regs_i (
    .clk       (clk),
    .rst       (rst),
    .csr       (csr),
    .csr_rdata (csr_rdata),
    .done      (done),
    .start     (start),
    .qtd_conf  (qtd_conf),
    .base_addr (base_addr)
  );

  cgra_conf_line_fetch fetch_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .base_addr      (base_addr),
    .req_rd_data    (req_rd_data),
    .available_read (available_read),
    .rd_data        (rd_data),
    .rd_data_valid  (rd_data_valid),
    .mem_ready      (mem_ready),
    .mem_rd_en      (mem_rd_en),
    .mem_rd_addr    (mem_rd_addr),
    .mem_rd_data    (mem_rd_data),
    .mem_rd_valid   (mem_rd_valid)
  );

  cgra_pe_conf_control control_i (
    .clk            (clk),
    .rst            (rst),
    .start          (start),
    .qtd_conf       (qtd_conf),
    .available_read (available_read),
    .req_rd_data    (req_rd_data),
    .rd_data        (rd_data),
    .rd_data_valid  (rd_data_valid),
    .conf_bus       (conf_bus),
    .done           (done)
  );

  cgra_pe_conf_bank bank_i (
    .clk      (clk),
    .rst      (rst),
    .conf_bus (conf_bus),
    .pe_conf  (pe_conf)
  );

endmodule

`default_nettype wire

// ==== rtl/cgra_pe_conf_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module cgra_pe_conf_bank (
  input  wire                              clk,
  input  wire                              rst,
  input  wire cgra_conf_pkg::conf_bus_t    conf_bus,
  output logic [`CGRA_NUM_PE-1:0][`CGRA_PE_CONF_WIDTH-1:0] pe_conf
);

  logic [`CGRA_NUM_PE-1:0] pe_wr;

  // One-hot write select. Ids at or above the bank size match no entry
  // and the beat is dropped.
  always_comb begin
    pe_wr = '0;
    for (int i = 0; i < `CGRA_NUM_PE; i++) begin
      if (conf_bus.valid && (conf_bus.pe_id == i)) begin
        pe_wr[i] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pe_conf <= '0;
    end else begin
      for (int i = 0; i < `CGRA_NUM_PE; i++) begin
        if (pe_wr[i]) begin
          pe_conf[i] <= conf_bus.pe_conf;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cgra_pe_conf_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module cgra_pe_conf_control (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            start,
  input  wire [`CGRA_WORD_WIDTH-1:0]     qtd_conf,
  input  wire                            available_read,
  output logic                           req_rd_data,
  input  wire [`CGRA_CL_WIDTH-1:0]       rd_data,
  input  wire                            rd_data_valid,
  output cgra_conf_pkg::conf_bus_t       conf_bus,
  output logic                           done
);

  import cgra_conf_pkg::*;

  localparam int SLOT_W = $clog2(`CGRA_WORDS_PER_CL) + 1;
  localparam logic [SLOT_W-1:0] LINE_SLOTS = SLOT_W'(`CGRA_WORDS_PER_CL);

  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_SEND = 3'd1;
  localparam logic [2:0] ST_REQ  = 3'd2;
  localparam logic [2:0] ST_WAIT = 3'd3;
  localparam logic [2:0] ST_DONE = 3'd4;

  logic [2:0] state;
  logic [`CGRA_WORD_WIDTH-1:0] conf_cnt;
  logic [SLOT_W-1:0] slot_cnt;
  logic [`CGRA_CL_WIDTH-1:0] conf_cl;
  conf_word_t cur_word;
  logic send_step;
  logic bus_valid;
  logic [`CGRA_PE_ID_WIDTH-1:0] bus_id;
  logic [`CGRA_PE_CONF_WIDTH-1:0] bus_conf;

  // The word to send next always sits at the bottom of the held line.
  assign cur_word = conf_cl[`CGRA_WORD_WIDTH-1:0];

  assign send_step = (state == ST_SEND) && (conf_cnt < qtd_conf) && (slot_cnt < LINE_SLOTS);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ST_IDLE;
      conf_cnt    <= '0;
      slot_cnt    <= LINE_SLOTS;
      req_rd_data <= 1'b0;
      bus_valid   <= 1'b0;
      done        <= 1'b0;
    end else begin
      req_rd_data <= 1'b0;
      bus_valid   <= send_step;
      case (state)
        ST_IDLE, ST_DONE: begin
          // A full slot count marks the line as used up, forcing a fetch.
          if (start) begin
            state    <= ST_SEND;
            conf_cnt <= '0;
            slot_cnt <= LINE_SLOTS;
            done     <= 1'b0;
          end
        end
        ST_SEND: begin
          if (conf_cnt >= qtd_conf) begin
            state <= ST_DONE;
            done  <= 1'b1;
          end else if (send_step) begin
            conf_cnt <= conf_cnt + 1'b1;
            slot_cnt <= slot_cnt + 1'b1;
          end else begin
            slot_cnt <= '0;
            state    <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (available_read) begin
            req_rd_data <= 1'b1;
            state       <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (rd_data_valid) begin
            state <= ST_SEND;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == ST_WAIT) && rd_data_valid) begin
      conf_cl <= rd_data;
    end else if (send_step) begin
      conf_cl <= conf_cl >> `CGRA_WORD_WIDTH;
    end
    if (send_step) begin
      bus_id   <= cur_word.pe_id;
      bus_conf <= cur_word.pe_conf;
    end
  end

  assign conf_bus = '{valid: bus_valid, pe_id: bus_id, pe_conf: bus_conf};

endmodule

`default_nettype wire

// ==== rtl/cgra_conf_line_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module cgra_conf_line_fetch (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            start,
  input  wire [`CGRA_ADDR_WIDTH-1:0]     base_addr,
  input  wire                            req_rd_data,
  output logic                           available_read,
  output logic [`CGRA_CL_WIDTH-1:0]      rd_data,
  output logic                           rd_data_valid,
  input  wire                            mem_ready,
  output logic                           mem_rd_en,
  output logic [`CGRA_ADDR_WIDTH-1:0]    mem_rd_addr,
  input  wire [`CGRA_CL_WIDTH-1:0]       mem_rd_data,
  input  wire                            mem_rd_valid
);

  // Lines already requested in the current run.
  logic [`CGRA_ADDR_WIDTH-1:0] line_cnt;
  logic outstanding;

  assign available_read = mem_ready && !outstanding;

  always_ff @(posedge clk) begin
    if (rst) begin
      line_cnt      <= '0;
      outstanding   <= 1'b0;
      mem_rd_en     <= 1'b0;
      rd_data_valid <= 1'b0;
    end else begin
      mem_rd_en     <= req_rd_data;
      rd_data_valid <= mem_rd_valid;
      if (start) begin
        line_cnt <= '0;
      end else if (req_rd_data) begin
        line_cnt <= line_cnt + 1'b1;
      end
      // Only one line is in flight at a time.
      if (req_rd_data) begin
        outstanding <= 1'b1;
      end else if (mem_rd_valid) begin
        outstanding <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_rd_data) begin
      mem_rd_addr <= base_addr + line_cnt;
    end
    if (mem_rd_valid) begin
      rd_data <= mem_rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cgra_conf_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_conf_consts.svh"

module cgra_conf_regs (
  input  wire                              clk,
  input  wire                              rst,
  input  wire cgra_conf_pkg::csr_req_t     csr,
  output logic [`CGRA_WORD_WIDTH-1:0]      csr_rdata,
  input  wire                              done,
  output logic                             start,
  output logic [`CGRA_WORD_WIDTH-1:0]      qtd_conf,
  output logic [`CGRA_ADDR_WIDTH-1:0]      base_addr
);

  localparam logic [`CGRA_CSR_ADDR_WIDTH-1:0] ADDR_COUNT  = 2'd0;
  localparam logic [`CGRA_CSR_ADDR_WIDTH-1:0] ADDR_BASE   = 2'd1;
  localparam logic [`CGRA_CSR_ADDR_WIDTH-1:0] ADDR_CTRL   = 2'd2;
  localparam logic [`CGRA_CSR_ADDR_WIDTH-1:0] ADDR_STATUS = 2'd3;

  logic busy;
  logic done_d;
  logic busy_flag;
  logic [`CGRA_WORD_WIDTH-1:0] status_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      qtd_conf  <= '0;
      base_addr <= '0;
      start     <= 1'b0;
      busy      <= 1'b0;
      done_d    <= 1'b0;
    end else begin
      start  <= csr.wr && (csr.addr == ADDR_CTRL) && csr.wdata[0];
      done_d <= done;
      if (csr.wr && (csr.addr == ADDR_COUNT)) begin
        qtd_conf <= csr.wdata;
      end
      if (csr.wr && (csr.addr == ADDR_BASE)) begin
        base_addr <= csr.wdata;
      end
      // Busy ends on the rising edge of done, so a stale done from the
      // previous run does not clear it.
      if (start) begin
        busy <= 1'b1;
      end else if (done && !done_d) begin
        busy <= 1'b0;
      end
    end
  end

  // The start pulse counts as busy already, so a status read in the same
  // cycle shows the load as running.
  assign busy_flag = busy | start;

  always_comb begin
    status_word    = '0;
    status_word[0] = done;
    status_word[1] = busy_flag;
  end

  always_comb begin
    csr_rdata = '0;
    if (csr.rd) begin
      case (csr.addr)
        ADDR_COUNT:  csr_rdata = qtd_conf;
        ADDR_BASE:   csr_rdata = base_addr;
        ADDR_STATUS: csr_rdata = status_word;
        default:     csr_rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cgra_conf_pkg.sv ====
`default_nettype none

`include "cgra_conf_consts.svh"

package cgra_conf_pkg;

  // One configuration word as stored in a memory line, word k at bits 32k+31:32k.
  typedef struct packed {
    logic [`CGRA_PE_CONF_WIDTH-1:0] pe_conf;
    logic [`CGRA_WORD_WIDTH-`CGRA_PE_CONF_WIDTH-`CGRA_PE_ID_WIDTH-1:0] reserved;
    logic [`CGRA_PE_ID_WIDTH-1:0] pe_id;
  } conf_word_t;

  // One beat on the configuration bus between the controller and the PE bank.
  typedef struct packed {
    logic valid;
    logic [`CGRA_PE_ID_WIDTH-1:0] pe_id;
    logic [`CGRA_PE_CONF_WIDTH-1:0] pe_conf;
  } conf_bus_t;

  // One register access. Address 0 is the count, 1 the base line address,
  // 2 the control word (bit 0 starts a load) and 3 the status (done, busy).
  typedef struct packed {
    logic wr;
    logic rd;
    logic [`CGRA_CSR_ADDR_WIDTH-1:0] addr;
    logic [`CGRA_WORD_WIDTH-1:0] wdata;
  } csr_req_t;

endpackage

`default_nettype wire

// ==== rtl/cgra_conf_consts.svh ====
`ifndef CGRA_CONF_CONSTS_SVH
`define CGRA_CONF_CONSTS_SVH

// Memory line and configuration word geometry.
`define CGRA_CL_WIDTH 512
`define CGRA_WORD_WIDTH 32
`define CGRA_WORDS_PER_CL 16

// PE bank size and the fields of one configuration word.
`define CGRA_NUM_PE 16
`define CGRA_PE_ID_WIDTH 5
`define CGRA_PE_CONF_WIDTH 16

// Address widths of the memory line port and the register block.
`define CGRA_ADDR_WIDTH 32
`define CGRA_CSR_ADDR_WIDTH 2

`endif
